/* Makefile */
VERILATOR ?= verilator
TOP       ?= cr16ExecTb
FILELIST  ?= cr16Exec.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* cr16Exec.f */
hdl/cr16Pkg.sv
hdl/cr16Alu.sv
hdl/regFile.sv
hdl/instrDecode.sv
hdl/cr16Exec.sv
dv/cr16ExecTb.sv

/* dv/cr16ExecTb.sv */
`timescale 1ns/1ns

module cr16ExecTb
    import cr16Pkg::*;
();

    localparam int clkPeriod  = 8;
    localparam int arithCount = 200;
    localparam int carryCount = 10;
    localparam int cmpCount   = 30;
    localparam int logicCount = 40;
    localparam int shiftCount = 24;

    // Transfer count per section sizes the watchdog
    localparam int totalXfers = (regCount + 1)              // Reset readback
        + regCount + arithCount * 5                         // Preload pair, run, two reads
        + carryCount * 17
        + cmpCount * 14
        + logicCount * 26
        + shiftCount * 28
        + 45;                                               // Error section
    localparam longint watchdogNs = longint'(totalXfers) * 3 * clkPeriod * 2
                                    + 8 * clkPeriod;

    localparam logic [7:0] arithOps [6] = '{opAdd, opAddu, opAddi, opAddui, opSub, opSubi};
    localparam logic [7:0] shiftOps [6] = '{opLsh, opLshi, opRsh, opRshi, opAlsh, opArsh};
    localparam logic [7:0] badAddrs [6] = '{8'h08, 8'h3C, 8'h41, 8'h80, 8'hFC, 8'h02};

    logic        clk;
    logic        rstN;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0]          rngState;
    logic [dataWidth-1:0] shadowRegs [regCount];   // Expected register state
    logic [4:0]           shadowFlags;
    int                   errorCount;
    int                   checkCount;
    string                nameQ [$];
    logic [31:0]          expQ [$];
    logic [31:0]          actQ [$];
    string                cmpName;
    logic [31:0]          cmpExp;
    logic [31:0]          cmpAct;

    cr16Exec uut (
        .clk     (clk),
        .rstN    (rstN),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic logic [7:0] regAddr(input logic [3:0] n);
        return addrRegBase + {2'b00, n, 2'b00};   // Word stride
    endfunction

    function automatic logic isImmForm(input logic [7:0] op);
        return op inside {opAddi, opAddui, opAddcui, opCmpi, opLshi, opRshi, opSubi};
    endfunction

    // Expected {flags, result} from the ALU rules
    function automatic logic [20:0] aluModel(
        input logic [7:0]  op,
        input logic [15:0] a,
        input logic [15:0] b,
        input logic [4:0]  fin
    );
        logic [16:0] wide;
        logic [15:0] res;
        logic [15:0] fill;
        logic [4:0]  fl;
        int          amt;
        res  = 16'h0;
        fl   = 5'h0;
        wide = 17'h0;
        fill = {16{a[15]}};
        amt  = (b == 16'h0) ? 1 : int'(b);         // Zero shifts by one
        case (op)
            opAdd, opAddi, opAddc:
            begin
                wide = {1'b0, a} + {1'b0, b};
                if (op == opAddc)
                    wide = wide + {16'h0, fin[flagC]};
                res       = wide[15:0];
                fl[flagF] = (a[15] == b[15]) && (res[15] != a[15]);
                fl[flagZ] = (res == 16'h0);
            end
            opAddu, opAddui, opAddcu, opAddcui, opAddci:
            begin
                if (op == opAddci)
                    wide = {1'b0, a} + {16'h0, fin[flagC]};   // No B term
                else if (op == opAddu || op == opAddui)
                    wide = {1'b0, a} + {1'b0, b};
                else
                    wide = {1'b0, a} + {1'b0, b} + {16'h0, fin[flagC]};
                res       = wide[15:0];
                fl[flagC] = wide[16];
                fl[flagZ] = (res == 16'h0);
            end
            opSub, opSubi:
            begin
                res       = a - b;
                fl[flagF] = (a[15] != b[15]) && (res[15] != a[15]);
                fl[flagZ] = (res == 16'h0);
            end
            opCmp, opCmpi:
            begin
                fl[flagZ] = (a == b);
                fl[flagL] = ($signed(a) < $signed(b));
                fl[flagN] = ($signed(a) < $signed(b));
            end
            opCmpu:
            begin
                fl[flagZ] = (a == b);
                fl[flagL] = (a < b);
            end
            opAnd: res = a & b;
            opOr:  res = a | b;
            opXor: res = a ^ b;
            opNot: res = ~a;
            opLsh, opLshi, opAlsh:
            begin
                res = (amt >= 16) ? 16'h0 : a << amt;
                fl  = fin;
            end
            opRsh:
            begin
                res = (amt >= 16) ? 16'h0 : a >> amt;
                fl  = fin;
            end
            opRshi, opArsh:
            begin
                res = (amt >= 16) ? fill : (a >> amt) | (fill & ~(16'hFFFF >> amt));
                fl  = fin;
            end
            opNop: fl = fin;
            default: ;                              // Zero result, zero flags
        endcase
        return {fl, res};
    endfunction

    function automatic void queueCheck(
        input string       name,
        input logic [31:0] exp,
        input logic [31:0] act
    );
        nameQ.push_back(name);
        expQ.push_back(exp);
        actQ.push_back(act);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // APB master
    // Setup cycle then access until pready with outputs sampled on falling edges
    task automatic busTransfer(
        input  logic [7:0]  addr,
        input  logic        write,
        input  logic [31:0] wdata,
        output logic [31:0] rdata,
        output logic        err
    );
        int waitCycles;
        waitCycles = 0;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && waitCycles < 8)
        begin
            waitCycles++;
            @(negedge clk);
        end
        if (!pready)
        begin
            errorCount++;
            $display("pready never rose on the APB transfer to address 0x%02h", addr);
        end
        queueCheck($sformatf("wait states 0x%02h", addr), 32'd1, 32'(waitCycles));
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);                             // Completing edge
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apbWrite(
        input logic [7:0]  addr,
        input logic [31:0] data,
        input logic        expErr,
        input string       name
    );
        logic [31:0] rdata;
        logic        err;
        busTransfer(addr, 1'b1, data, rdata, err);
        queueCheck({name, " pslverr"}, {31'h0, expErr}, {31'h0, err});
    endtask

    task automatic apbRead(
        input logic [7:0]  addr,
        input logic [31:0] expData,
        input logic        expErr,
        input string       name
    );
        logic [31:0] rdata;
        logic        err;
        busTransfer(addr, 1'b0, 32'h0, rdata, err);
        queueCheck({name, " pslverr"}, {31'h0, expErr}, {31'h0, err});
        queueCheck(name, expData, rdata);
    endtask

    task automatic preloadReg(input logic [3:0] n, input logic [15:0] value);
        apbWrite(regAddr(n), {16'h0, value}, 1'b0, "preload");
        shadowRegs[n] = value;
    endtask

    // Execute one instruction, update the shadow state, read back Rdest and flags
    task automatic runInstr(
        input logic [7:0]  op,
        input logic [3:0]  rd,
        input logic [3:0]  rs,
        input logic [15:0] imm,
        input string       name
    );
        logic [15:0] b;
        logic [20:0] model;
        b     = isImmForm(op) ? imm : shadowRegs[rs];
        model = aluModel(op, shadowRegs[rd], b, shadowFlags);
        apbWrite(addrInstr, {imm, rs, rd, op}, 1'b0, name);
        if (!(op inside {opCmp, opCmpi, opCmpu, opNop}))
            shadowRegs[rd] = model[15:0];
        if (op != opNop)
            shadowFlags = model[20:16];
        apbRead(regAddr(rd), {16'h0, shadowRegs[rd]}, 1'b0, {name, " rDest"});
        apbRead(addrFlags, {27'h0, shadowFlags}, 1'b0, {name, " flags"});
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checker
    always @(posedge clk)
    begin
        while (actQ.size() > 0)
        begin
            cmpName = nameQ.pop_front();
            cmpExp  = expQ.pop_front();
            cmpAct  = actQ.pop_front();
            checkCount++;
            if (cmpAct !== cmpExp)
            begin
                errorCount++;
                $display("FAILED %s expected 0x%08h actual 0x%08h", cmpName, cmpExp, cmpAct);
            end
        end
    end

    initial
    begin
        #(watchdogNs);
        $display("Simulation hung, watchdog expired after %0d ns", watchdogNs);
        $display("sim failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    initial
    begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [15:0] va;
        logic [15:0] vb;
        logic [15:0] imm;
        logic [15:0] amt;
        logic [7:0]  op;
        rngState    = 32'h6de8;
        errorCount  = 0;
        checkCount  = 0;
        shadowFlags = 5'h0;
        for (int i = 0; i < regCount; i++)
            shadowRegs[i] = 16'h0;
        rstN    <= 1'b0;
        paddr   <= 8'h0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        pwdata  <= 32'h0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        // Everything reads zero after reset
        for (int i = 0; i < regCount; i++)
            apbRead(regAddr(4'(i)), 32'h0, 1'b0, $sformatf("reset reg %0d", i));
        apbRead(addrFlags, 32'h0, 1'b0, "reset flags");

        // Random add and subtract
        for (int i = 0; i < regCount; i++)
        begin
            r = nextRand();
            preloadReg(4'(i), r[15:0]);
        end
        for (int n = 0; n < arithCount; n++)
        begin
            r  = nextRand();
            r2 = nextRand();
            rd = r[3:0];
            rs = r[7:4];
            op = arithOps[r[30:28] % 3'd6];
            va = r2[15:0];
            if (r[26:24] == 3'd0)
                vb = (op == opSub || op == opSubi) ? va : 16'h0 - va;  // Force Z
            else
                vb = r2[31:16];
            imm = (r[26:24] == 3'd0) ? vb : r[23:8];
            preloadReg(rd, va);
            preloadReg(rs, vb);
            runInstr(op, rd, rs, imm, $sformatf("arith %0d op %02h", n, op));
        end

        // Carry chain with both MSBs set so ADDU carries out
        for (int n = 0; n < carryCount; n++)
        begin
            r  = nextRand();
            r2 = nextRand();
            rd = r[3:0];
            rs = rd + 4'd1;
            preloadReg(rd, r[15:0] | 16'h8000);
            preloadReg(rs, r2[15:0] | 16'h8000);
            runInstr(opAddu, rd, rs, r2[31:16], "carry addu");
            runInstr(opAddcu, rd, rs, r2[31:16], "carry addcu");
            runInstr(opAddcui, rd, rs, r2[31:16], "carry addcui");
            runInstr(opAddci, rd, rs, r2[31:16], "carry addci");
            runInstr(opAddc, rd, rs, r2[31:16], "carry addc");
        end

        // Compares and NOP
        for (int n = 0; n < cmpCount; n++)
        begin
            r  = nextRand();
            r2 = nextRand();
            rd = r[3:0];
            rs = r[7:4];
            va = r2[15:0];
            vb = (r2[2:0] == 3'd0) ? va : r2[31:16];   // Some equal pairs
            preloadReg(rd, va);
            preloadReg(rs, vb);
            imm = (r[10:8] == 3'd0) ? shadowRegs[rd] : r[31:16];
            runInstr(opCmp, rd, rs, imm, "cmp");
            runInstr(opCmpi, rd, rs, imm, "cmpi");
            runInstr(opCmpu, rd, rs, imm, "cmpu");
            runInstr(opNop, rd, rs, imm, "nop");
        end

        // Logic ops, each after a compare that sets Z
        for (int n = 0; n < logicCount; n++)
        begin
            r  = nextRand();
            r2 = nextRand();
            rd = r[3:0];
            rs = r[7:4];
            preloadReg(rd, r2[15:0]);
            preloadReg(rs, r2[31:16]);
            runInstr(opCmp, rd, rd, 16'h0, "logic flag setup");
            runInstr(opAnd, rd, rs, r[31:16], "and");
            runInstr(opCmp, rd, rd, 16'h0, "logic flag setup");
            runInstr(opOr, rd, rs, r[31:16], "or");
            runInstr(opCmp, rd, rd, 16'h0, "logic flag setup");
            runInstr(opXor, rd, rs, r[31:16], "xor");
            runInstr(opCmp, rd, rd, 16'h0, "logic flag setup");
            runInstr(opNot, rd, rs, r[31:16], "not");
        end

        // Shifts with amounts of zero, 1 to 15, and 16 and up
        for (int n = 0; n < shiftCount; n++)
        begin
            r  = nextRand();
            r2 = nextRand();
            rd = r[3:0];
            rs = rd ^ 4'h8;
            case (n % 3)
                0:       amt = 16'h0;
                1:       amt = 16'(r2[3:0] % 4'd15) + 16'd1;
                default: amt = 16'h10 | r2[15:0];
            endcase
            preloadReg(rs, amt);
            runInstr(opCmp, rs, rs, amt, "shift flag setup");  // Equal so Z set
            for (int k = 0; k < 6; k++)
            begin
                preloadReg(rd, r[31:16]);
                runInstr(shiftOps[k], rd, rs, amt,
                         $sformatf("shift op %02h amt %0d", shiftOps[k], amt));
            end
        end

        // Bus errors change nothing
        for (int i = 0; i < 6; i++)
        begin
            apbWrite(badAddrs[i], nextRand(), 1'b1, $sformatf("write 0x%02h", badAddrs[i]));
            apbRead(badAddrs[i], 32'h0, 1'b1, $sformatf("read 0x%02h", badAddrs[i]));
        end
        apbWrite(addrFlags, 32'h1F, 1'b1, "flags write");
        for (int i = 0; i < regCount; i++)
            apbRead(regAddr(4'(i)), {16'h0, shadowRegs[i]}, 1'b0,
                    $sformatf("after errors reg %0d", i));
        apbRead(addrFlags, {27'h0, shadowFlags}, 1'b0, "after errors flags");

        // Flags set first so the unknown opcode clear shows
        preloadReg(4'h3, 16'h0001);
        preloadReg(4'h5, 16'h0002);
        runInstr(opCmpu, 4'h3, 4'h5, 16'h0, "unknown setup 1");
        runInstr(8'h18, 4'h5, 4'h3, 16'h1234, "unknown 0x18");
        runInstr(opCmp, 4'h5, 4'h3, 16'h0, "unknown setup 2");
        runInstr(8'hFF, 4'h3, 4'h5, 16'hABCD, "unknown 0xff");
        apbRead(addrInstr, {16'hABCD, 4'h5, 4'h3, 8'hFF}, 1'b0, "last instruction");

        repeat (2) @(posedge clk);                  // Drain checker
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* hdl/cr16Alu.sv */
`timescale 1ns/1ns

module cr16Alu
    import cr16Pkg::*;
(
    input  logic [dataWidth-1:0] a,        // Rdest value
    input  logic [dataWidth-1:0] b,        // Rsrc or immediate
    input  logic [7:0]           op,
    input  logic [4:0]           flagsIn,  // Current flag register
    output logic [dataWidth-1:0] result,
    output logic [4:0]           flagsOut
);

    // Same sign in, different sign out
    function automatic logic addOverflow(
        input logic [dataWidth-1:0] x,
        input logic [dataWidth-1:0] y,
        input logic [dataWidth-1:0] s
    );
        return (x[dataWidth-1] == y[dataWidth-1]) && (s[dataWidth-1] != x[dataWidth-1]);
    endfunction

    // Operands differ in sign and result sign left A
    function automatic logic subOverflow(
        input logic [dataWidth-1:0] x,
        input logic [dataWidth-1:0] y,
        input logic [dataWidth-1:0] s
    );
        return (x[dataWidth-1] != y[dataWidth-1]) && (s[dataWidth-1] != x[dataWidth-1]);
    endfunction

    logic                 cIn;
    logic [dataWidth:0]   sumAB;       // Extra bit holds carry out
    logic [dataWidth:0]   sumABC;
    logic [dataWidth:0]   sumAC;
    logic [dataWidth-1:0] diff;
    logic [dataWidth-1:0] shAmt;
    logic [dataWidth-1:0] lshRes;
    logic [dataWidth-1:0] rshRes;
    logic [dataWidth-1:0] arshRes;
    logic                 zeroCheck;   // Arithmetic ops derive Z from result

    assign cIn    = flagsIn[flagC];
    assign sumAB  = {1'b0, a} + {1'b0, b};
    assign sumABC = sumAB + {{dataWidth{1'b0}}, cIn};
    assign sumAC  = {1'b0, a} + {{dataWidth{1'b0}}, cIn};
    assign diff   = a - b;

    ////////////////////////////////////////////////////////////////////////////
    // Shifter
    // Zero amount means shift by one
    assign shAmt   = (b == '0) ? dataWidth'(1) : b;
    // 16 or more pushes every data bit out, leaving fill only
    assign lshRes  = a << shAmt;
    assign rshRes  = a >> shAmt;
    assign arshRes = $signed(a) >>> shAmt;  // Sign fill

    ////////////////////////////////////////////////////////////////////////////
    // Result and flag select
    always_comb
    begin
        result    = '0;     // Unknown opcode leaves zeros
        flagsOut  = '0;
        zeroCheck = 1'b0;
        case (op)
            opAdd, opAddi:
            begin
                result          = sumAB[dataWidth-1:0];
                flagsOut[flagF] = addOverflow(a, b, result);  // C stays clear
                zeroCheck       = 1'b1;
            end
            opAddu, opAddui:
            begin
                {flagsOut[flagC], result} = sumAB;  // F stays clear
                zeroCheck                 = 1'b1;
            end
            opAddc:
            begin
                result          = sumABC[dataWidth-1:0];
                flagsOut[flagF] = addOverflow(a, b, result);
                zeroCheck       = 1'b1;
            end
            opAddcu, opAddcui:
            begin
                {flagsOut[flagC], result} = sumABC;
                zeroCheck                 = 1'b1;
            end
            opAddci:
            begin
                {flagsOut[flagC], result} = sumAC;  // B ignored
                zeroCheck                 = 1'b1;
            end
            opSub, opSubi:
            begin
                result          = diff;
                flagsOut[flagF] = subOverflow(a, b, result);
                zeroCheck       = 1'b1;
            end
            opCmp, opCmpi:
            begin
                flagsOut[flagZ] = (a == b);
                if ($signed(a) < $signed(b))
                begin
                    flagsOut[flagL] = 1'b1;
                    flagsOut[flagN] = 1'b1;
                end
            end
            opCmpu:
            begin
                flagsOut[flagZ] = (a == b);
                flagsOut[flagL] = (a < b);  // Unsigned, N untouched
            end
            // Logic ops leave all flags clear
            opAnd: result = a & b;
            opOr:  result = a | b;
            opXor: result = a ^ b;
            opNot: result = ~a;
            // Shifts pass flags through
            opLsh, opLshi, opAlsh:
            begin
                result   = lshRes;
                flagsOut = flagsIn;
            end
            opRsh:
            begin
                result   = rshRes;
                flagsOut = flagsIn;
            end
            opRshi, opArsh:
            begin
                result   = arshRes;
                flagsOut = flagsIn;
            end
            opNop:   flagsOut = flagsIn;  // Not written back anyway
            default: ;
        endcase
        if (zeroCheck)
            flagsOut[flagZ] = (result == '0);
    end

endmodule

/* hdl/cr16Exec.sv */
`timescale 1ns/1ns

module cr16Exec
    import cr16Pkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic                   instrHit;
    logic                   flagsHit;
    logic                   regHit;
    logic                   addrErr;
    logic [7:0]             regOffset;
    logic [regIdxWidth-1:0] regIdx;
    logic                   access;
    logic                   complete;
    logic                   execute;
    logic                   regWrite;
    logic                   regRead;
    logic [31:0]            lastInstr;
    logic [4:0]             flags;
    logic [7:0]             aluOp;
    logic [regIdxWidth-1:0] rDest;
    logic [regIdxWidth-1:0] rSrc;
    logic [dataWidth-1:0]   imm;
    logic                   useImm;
    logic                   writeBack;
    logic                   flagsWrite;
    logic [regIdxWidth-1:0] raddrB;
    logic                   rfWe;
    logic [regIdxWidth-1:0] rfWaddr;
    logic [dataWidth-1:0]   rfWdata;
    logic [dataWidth-1:0]   rdataA;
    logic [dataWidth-1:0]   rdataB;
    logic [dataWidth-1:0]   opB;
    logic [dataWidth-1:0]   aluResult;
    logic [4:0]             aluFlags;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    assign instrHit  = (paddr == addrInstr);
    assign flagsHit  = (paddr == addrFlags);
    assign regOffset = paddr - addrRegBase;
    assign regHit    = (paddr >= addrRegBase) && (regOffset < 8'(4 * regCount))
                       && (paddr[1:0] == 2'b00);  // Word aligned only
    assign regIdx    = regOffset[regIdxWidth+1:2];
    assign addrErr   = !(instrHit || regHit || (flagsHit && !pwrite));  // Flags read only

    assign access   = psel && penable;
    assign complete = access && pready;                     // Last access cycle
    assign execute  = complete && pwrite && instrHit;
    assign regWrite = complete && pwrite && regHit;         // Host preload
    assign regRead  = psel && !pwrite && regHit;

    // Single fixed wait state, then ready for one cycle
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end
        else
        begin
            pready  <= access && !pready;
            pslverr <= access && !pready && addrErr;
        end
    end

    // Sampled at end of wait, before any write of this transfer lands
    always_ff @(posedge clk)
    begin
        if (access && !pready)
        begin
            if (pwrite || addrErr)
                prdata <= '0;
            else if (instrHit)
                prdata <= lastInstr;
            else if (flagsHit)
                prdata <= {{(32 - 5){1'b0}}, flags};
            else
                prdata <= {{(32 - dataWidth){1'b0}}, rdataB};
        end
    end

    // Flag and last instruction registers
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            lastInstr <= '0;
            flags     <= '0;
        end
        else if (execute)
        begin
            lastInstr <= pwdata;
            if (flagsWrite)
                flags <= aluFlags;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    instrDecode decode (
        .instr      (pwdata),
        .aluOp      (aluOp),
        .rDest      (rDest),
        .rSrc       (rSrc),
        .imm        (imm),
        .useImm     (useImm),
        .writeBack  (writeBack),
        .flagsWrite (flagsWrite)
    );

    // Port B borrowed by host register reads
    assign raddrB  = regRead ? regIdx : rSrc;
    assign rfWe    = regWrite || (execute && writeBack);
    assign rfWaddr = regWrite ? regIdx : rDest;
    assign rfWdata = regWrite ? pwdata[dataWidth-1:0] : aluResult;

    regFile regs (
        .clk    (clk),
        .rstN   (rstN),
        .raddrA (rDest),
        .raddrB (raddrB),
        .we     (rfWe),
        .waddr  (rfWaddr),
        .wdata  (rfWdata),
        .rdataA (rdataA),
        .rdataB (rdataB)
    );

    assign opB = useImm ? imm : rdataB;

    cr16Alu alu (
        .a        (rdataA),
        .b        (opB),
        .op       (aluOp),
        .flagsIn  (flags),
        .result   (aluResult),
        .flagsOut (aluFlags)
    );

    // Ready only inside an access phase
    assert property (@(posedge clk) disable iff (!rstN) $rose(pready) |-> psel && penable)
        else $error("pready rose outside an APB access");

endmodule

/* hdl/cr16Pkg.sv */
package cr16Pkg;

    // Datapath sizing
    localparam int dataWidth   = 16;
    localparam int regCount    = 16;
    localparam int regIdxWidth = 4;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes
    localparam logic [7:0] opAdd    = 8'h00;
    localparam logic [7:0] opAddi   = 8'h01;
    localparam logic [7:0] opAddu   = 8'h02;
    localparam logic [7:0] opAddui  = 8'h03;
    localparam logic [7:0] opAddc   = 8'h04;
    localparam logic [7:0] opAddcu  = 8'h05;
    localparam logic [7:0] opAddcui = 8'h06;
    localparam logic [7:0] opAddci  = 8'h07;  // A plus carry only
    localparam logic [7:0] opSub    = 8'h08;
    localparam logic [7:0] opSubi   = 8'h09;
    localparam logic [7:0] opCmp    = 8'h0A;
    localparam logic [7:0] opCmpi   = 8'h0B;
    localparam logic [7:0] opCmpu   = 8'h0C;
    localparam logic [7:0] opAnd    = 8'h0D;
    localparam logic [7:0] opOr     = 8'h0E;
    localparam logic [7:0] opXor    = 8'h0F;
    localparam logic [7:0] opNot    = 8'h10;
    localparam logic [7:0] opLsh    = 8'h11;
    localparam logic [7:0] opLshi   = 8'h12;
    localparam logic [7:0] opRsh    = 8'h13;  // Logical
    localparam logic [7:0] opRshi   = 8'h14;  // Arithmetic
    localparam logic [7:0] opAlsh   = 8'h15;
    localparam logic [7:0] opArsh   = 8'h16;
    localparam logic [7:0] opNop    = 8'h17;

    // Flag bit positions
    localparam int flagZ = 4;  // Zero
    localparam int flagC = 3;  // Carry out
    localparam int flagF = 2;  // Signed overflow
    localparam int flagL = 1;  // Less, signed or unsigned
    localparam int flagN = 0;  // Signed less

    // Instruction word field LSBs
    localparam int opLsb    = 0;
    localparam int rDestLsb = 8;
    localparam int rSrcLsb  = 12;
    localparam int immLsb   = 16;

    ////////////////////////////////////////////////////////////////////////////
    // APB address map
    localparam logic [7:0] addrInstr   = 8'h00;  // Write executes
    localparam logic [7:0] addrFlags   = 8'h04;  // Read only
    localparam logic [7:0] addrRegBase = 8'h40;  // Reg n at base + 4n

endpackage

/* hdl/instrDecode.sv */
`timescale 1ns/1ns

module instrDecode
    import cr16Pkg::*;
(
    input  logic [31:0]            instr,
    output logic [7:0]             aluOp,
    output logic [regIdxWidth-1:0] rDest,
    output logic [regIdxWidth-1:0] rSrc,
    output logic [dataWidth-1:0]   imm,
    output logic                   useImm,      // B from immediate
    output logic                   writeBack,   // Result to Rdest
    output logic                   flagsWrite   // Load flag register
);

    ////////////////////////////////////////////////////////////////////////////
    // Field extraction
    assign aluOp = instr[opLsb +: 8];
    assign rDest = instr[rDestLsb +: regIdxWidth];
    assign rSrc  = instr[rSrcLsb +: regIdxWidth];
    assign imm   = instr[immLsb +: dataWidth];

    // Immediate forms
    // ADDCI takes no B so it stays on the register path
    assign useImm = aluOp inside {
        opAddi,
        opAddui,
        opAddcui,
        opCmpi,
        opLshi,
        opRshi,
        opSubi
    };

    // Compares only touch flags
    assign writeBack = !(aluOp inside {opCmp, opCmpi, opCmpu, opNop});

    // Unknown opcodes still write, giving zero result and zero flags
    assign flagsWrite = (aluOp != opNop);

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ns

module regFile
    import cr16Pkg::*;
(
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [regIdxWidth-1:0] raddrA,
    input  logic [regIdxWidth-1:0] raddrB,
    input  logic                   we,
    input  logic [regIdxWidth-1:0] waddr,
    input  logic [dataWidth-1:0]   wdata,
    output logic [dataWidth-1:0]   rdataA,
    output logic [dataWidth-1:0]   rdataB
);

    logic [dataWidth-1:0] regs [regCount];

    // Architectural state, cleared on reset
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < regCount; i++)
                regs[i] <= '0;
        end
        else if (we)
            regs[waddr] <= wdata;
    end

    // Combinational reads, old value when written same cycle
    assign rdataA = regs[raddrA];
    assign rdataB = regs[raddrB];

    // Write strobe comes from the APB decode in the top level
    assert property (@(posedge clk) disable iff (!rstN) !$isunknown(we))
        else $error("regFile write enable unknown");

endmodule
